/* Bender.yml */
package:
  name: fadds

sources:
  - fp_types_pkg.sv
  - fadd_ctrl_pkg.sv
  - fadd_classify.sv
  - fadd_align.sv
  - fadd_mant_add.sv
  - fadd_round.sv
  - fadds.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_fadds.sv

/* fadd_align.sv */
// Stage 1 arithmetic path of the adder.
// Orders the operands by magnitude, works out the result sign and whether
// the significands are subtracted, and shifts the smaller significand right
// into a guard/round/sticky extended field. Both-zero inputs fall through
// here with zero significands so the sign rules apply in stage 2.

`timescale 1ns/1ps
`default_nettype none

module fadd_align (
  input  logic                  clk,
  input  logic                  rst,
  input  fadd_ctrl_pkg::op_e    op,
  input  fp_types_pkg::fp32_t   a,
  input  fp_types_pkg::fp32_t   b,
  output fadd_ctrl_pkg::align_t al
);
  import fp_types_pkg::*;
  import fadd_ctrl_pkg::*;

  localparam int AW = SIG_W + GRS_W;

  logic             sa;
  logic             sb;
  logic             a_ge;
  logic [SIG_W-1:0] sig_a;
  logic [SIG_W-1:0] sig_b;
  logic [SIG_W-1:0] sig_big;
  logic [SIG_W-1:0] sig_small;
  logic [EXP_W-1:0] exp_big;
  logic [EXP_W-1:0] exp_small;
  logic [EXP_W-1:0] diff;
  logic [AW-1:0]    ext_s;
  logic [2*AW-1:0]  wide;
  logic [AW-1:0]    sig_al;
  align_t           al_d;

  assign sa = a.sign ^ (op == OP_RSUB);
  assign sb = b.sign ^ (op == OP_SUB);

  // hidden bit, denormals flushed
  assign sig_a = (a.exp == '0) ? '0 : {1'b1, a.frac};
  assign sig_b = (b.exp == '0) ? '0 : {1'b1, b.frac};

  // exponent first, then fraction
  assign a_ge = {a.exp, a.frac} >= {b.exp, b.frac};

  assign sig_big   = a_ge ? sig_a : sig_b;
  assign sig_small = a_ge ? sig_b : sig_a;
  assign exp_big   = a_ge ? a.exp : b.exp;
  assign exp_small = a_ge ? b.exp : a.exp;
  assign diff      = exp_big - exp_small;

  assign ext_s = {sig_small, {GRS_W{1'b0}}};
  assign wide  = {ext_s, {AW{1'b0}}} >> diff;

  always_comb begin
    if (diff >= EXP_W'(AW - 1)) begin
      // whole significand lands in sticky
      sig_al = {{(AW-1){1'b0}}, |sig_small};
    end else begin
      sig_al = {wide[2*AW-1:AW+1], wide[AW] | (|wide[AW-1:0])};
    end
  end

  always_comb begin
    al_d.sign    = a_ge ? sa : sb;
    al_d.eff_sub = sa ^ sb;
    al_d.exp     = exp_big;
    al_d.sig_l   = sig_big;
    al_d.sig_s   = sig_al;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      al <= '0;
    end else begin
      al <= al_d;
    end
  end

endmodule

`default_nettype wire

/* fadd_classify.sv */
// Stage 1 special-case path of the adder.
// Picks out NaN, infinity and zero operands and computes the logic ops,
// producing a ready-made result that stage 2 selects when is_spec is set.
// Zero plus zero is left to the arithmetic path.

`timescale 1ns/1ps
`default_nettype none

module fadd_classify (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    en,
  input  fadd_ctrl_pkg::op_e      op,
  input  fp_types_pkg::fp32_t     a,
  input  fp_types_pkg::fp32_t     b,
  output fadd_ctrl_pkg::special_t spec,
  output logic                    en_q
);
  import fp_types_pkg::*;
  import fadd_ctrl_pkg::*;

  logic     sa;
  logic     sb;
  logic     a_zero;
  logic     b_zero;
  logic     a_inf;
  logic     b_inf;
  logic     a_nan;
  logic     b_nan;
  logic     a_snan;
  logic     b_snan;
  logic     is_logic;
  special_t spec_d;

  // effective signs after the opcode's negation
  assign sa = a.sign ^ (op == OP_RSUB);
  assign sb = b.sign ^ (op == OP_SUB);

  // denormals count as zero
  assign a_zero = (a.exp == '0);
  assign b_zero = (b.exp == '0);
  assign a_inf  = (a.exp == EXP_MAX) && (a.frac == '0);
  assign b_inf  = (b.exp == EXP_MAX) && (b.frac == '0);
  assign a_nan  = (a.exp == EXP_MAX) && (a.frac != '0);
  assign b_nan  = (b.exp == EXP_MAX) && (b.frac != '0);
  assign a_snan = a_nan && !a.frac[FRAC_W-1];
  assign b_snan = b_nan && !b.frac[FRAC_W-1];

  assign is_logic = (op == OP_AND) || (op == OP_OR) || (op == OP_XOR) || (op == OP_ANDN);

  always_comb begin
    spec_d.is_spec = 1'b1;
    spec_d.invalid = 1'b0;
    spec_d.val     = QNAN_VAL;
    if (is_logic) begin
      case (op)
        OP_AND:  spec_d.val = a & b;
        OP_OR:   spec_d.val = a | b;
        OP_XOR:  spec_d.val = a ^ b;
        default: spec_d.val = a & ~b;
      endcase
    end else if (a_nan || b_nan) begin
      spec_d.invalid = a_snan | b_snan;
    end else if (a_inf && b_inf) begin
      // inf - inf stays at the default qnan
      if (sa != sb) begin
        spec_d.invalid = 1'b1;
      end else begin
        spec_d.val = '{sign: sa, exp: EXP_MAX, frac: '0};
      end
    end else if (a_inf) begin
      spec_d.val = '{sign: sa, exp: EXP_MAX, frac: '0};
    end else if (b_inf) begin
      spec_d.val = '{sign: sb, exp: EXP_MAX, frac: '0};
    end else if (a_zero && !b_zero) begin
      spec_d.val = '{sign: sb, exp: b.exp, frac: b.frac};
    end else if (b_zero && !a_zero) begin
      spec_d.val = '{sign: sa, exp: a.exp, frac: a.frac};
    end else begin
      spec_d.is_spec = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q <= 1'b0;
      spec <= '0;
    end else begin
      en_q <= en;
      spec <= spec_d;
    end
  end

endmodule

`default_nettype wire

/* fadd_ctrl_pkg.sv */
// Operation control types for the pipelined adder.
// Opcodes, rounding modes, the exception flags and the records that
// stage 1 hands to stage 2.

`default_nettype none

package fadd_ctrl_pkg;

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_RSUB = 3'd2,
    OP_AND  = 3'd3,
    OP_OR   = 3'd4,
    OP_XOR  = 3'd5,
    OP_ANDN = 3'd6
  } op_e;

  typedef enum logic [1:0] {
    RND_TRUNC = 2'd0,
    RND_EVEN  = 2'd1,
    RND_PLUS  = 2'd2,
    RND_MINUS = 2'd3
  } round_mode_e;

  typedef struct packed {
    logic invalid;
    logic overflow;
    logic underflow;
    logic inexact;
  } fadd_flags_t;

  // aligned operands, larger one first
  typedef struct packed {
    logic                                                 sign;
    logic                                                 eff_sub;
    logic [fp_types_pkg::EXP_W-1:0]                       exp;
    logic [fp_types_pkg::SIG_W-1:0]                       sig_l;
    logic [fp_types_pkg::SIG_W+fp_types_pkg::GRS_W-1:0]   sig_s;
  } align_t;

  typedef struct packed {
    logic                is_spec;
    fp_types_pkg::fp32_t val;
    logic                invalid;
  } special_t;

endpackage

`default_nettype wire

/* fadd_mant_add.sv */
// Stage 2 significand adder and normalizer, purely combinational.
// Adds or subtracts the aligned significands and renormalizes so the
// hidden bit sits in the top position. The exponent is kept signed and
// wide enough that values below 1 reach the rounder as underflow.
// is_zero marks an exact cancellation under effective subtraction.

`timescale 1ns/1ps
`default_nettype none

module fadd_mant_add (
  input  fadd_ctrl_pkg::align_t                              al,
  output logic [fp_types_pkg::SIG_W+fp_types_pkg::GRS_W-1:0] sig,
  output logic signed [9:0]                                  exp_n,
  output logic                                               is_zero
);
  import fp_types_pkg::*;
  import fadd_ctrl_pkg::*;

  localparam int AW = SIG_W + GRS_W;

  logic [AW:0]       big;
  logic [AW:0]       sum;
  logic [4:0]        lz;
  logic              found;
  logic signed [9:0] exp_base;

  assign big = {1'b0, al.sig_l, {GRS_W{1'b0}}};

  // larger magnitude first, so the difference never goes negative
  assign sum = al.eff_sub ? big - {1'b0, al.sig_s} : big + {1'b0, al.sig_s};

  assign exp_base = signed'({2'b00, al.exp});
  assign is_zero  = al.eff_sub && (sum == '0);

  // leading zero count below the carry bit
  always_comb begin
    lz    = '0;
    found = 1'b0;
    for (int i = AW - 1; i >= 0; i--) begin
      if (!found) begin
        if (sum[i]) begin
          found = 1'b1;
        end else begin
          lz = lz + 5'd1;
        end
      end
    end
  end

  always_comb begin
    if (sum[AW]) begin
      // carry out, dropped bit folds into sticky
      sig   = {sum[AW:2], sum[1] | sum[0]};
      exp_n = exp_base + 10'sd1;
    end else begin
      sig   = sum[AW-1:0] << lz;
      exp_n = exp_base - signed'({5'b00000, lz});
    end
  end

endmodule

`default_nettype wire

/* fadd_round.sv */
// Stage 2 rounding and result register.
// Rounds the normalized significand in the selected mode, applies overflow,
// flush-to-zero underflow and signed-zero rules, and falls back to the
// stage 1 special value when one was flagged. res and flags only load on
// a valid cycle and otherwise hold the last result.

`timescale 1ns/1ps
`default_nettype none

module fadd_round (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                                               en_q,
  input  fadd_ctrl_pkg::round_mode_e                         rmode,
  input  logic                                               sign,
  input  logic [fp_types_pkg::SIG_W+fp_types_pkg::GRS_W-1:0] sig,
  input  logic signed [9:0]                                  exp_n,
  input  logic                                               is_zero,
  input  fadd_ctrl_pkg::special_t                            spec,
  output logic                                               valid,
  output fp_types_pkg::fp32_t                                res,
  output fadd_ctrl_pkg::fadd_flags_t                         flags
);
  import fp_types_pkg::*;
  import fadd_ctrl_pkg::*;

  localparam int AW = SIG_W + GRS_W;
  localparam logic signed [9:0] EXP_TOP = signed'({2'b00, EXP_MAX});

  logic [SIG_W-1:0]  mant;
  logic [GRS_W-1:0]  grs;
  logic              lost;
  logic              inc;
  logic [SIG_W:0]    mant_r;
  logic signed [9:0] exp_r;
  logic              to_inf;
  fp32_t             res_d;
  fadd_flags_t       flags_d;

  assign mant = sig[AW-1:GRS_W];
  assign grs  = sig[GRS_W-1:0];
  assign lost = |grs;

  always_comb begin
    case (rmode)
      RND_EVEN:  inc = grs[2] & (grs[1] | grs[0] | mant[0]);
      RND_PLUS:  inc = ~sign & lost;
      RND_MINUS: inc = sign & lost;
      default:   inc = 1'b0;
    endcase
  end

  assign mant_r = {1'b0, mant} + {{SIG_W{1'b0}}, inc};
  assign exp_r  = exp_n + signed'({9'b0, mant_r[SIG_W]});

  // modes that round away from zero for this sign overflow to infinity
  assign to_inf = (rmode == RND_EVEN) || ((rmode == RND_PLUS) && !sign) ||
                  ((rmode == RND_MINUS) && sign);

  always_comb begin
    res_d   = '0;
    flags_d = '0;
    if (spec.is_spec) begin
      res_d           = spec.val;
      flags_d.invalid = spec.invalid;
    end else if (!sig[AW-1]) begin
      // zero result, cancellation takes its sign from the mode
      res_d.sign = is_zero ? (rmode == RND_MINUS) : sign;
    end else if (exp_r >= EXP_TOP) begin
      flags_d.overflow = 1'b1;
      flags_d.inexact  = 1'b1;
      res_d.sign       = sign;
      if (to_inf) begin
        res_d.exp = EXP_MAX;
      end else begin
        res_d.exp  = EXP_MAX - 8'd1;
        res_d.frac = '1;
      end
    end else if (exp_r < 10'sd1) begin
      flags_d.underflow = 1'b1;
      flags_d.inexact   = 1'b1;
      res_d.sign        = sign;
    end else begin
      res_d.sign = sign;
      res_d.exp  = exp_r[EXP_W-1:0];
      // on a rounding carry the low bits are all zero anyway
      res_d.frac = mant_r[FRAC_W-1:0];
      flags_d.inexact = lost;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
      res   <= '0;
      flags <= '0;
    end else begin
      valid <= en_q;
      if (en_q) begin
        res   <= res_d;
        flags <= flags_d;
      end
    end
  end

endmodule

`default_nettype wire

/* fadds.f */
+incdir+.
fp_types_pkg.sv
fadd_ctrl_pkg.sv
fadd_classify.sv
fadd_align.sv
fadd_mant_add.sv
fadd_round.sv
fadds.sv
tb_fadds.sv

/* fadds.sv */
// Two-stage pipelined single-precision adder with a bitwise logic side path.
// Issue an operation by holding en high for one cycle with op, rmode, a
// and b; valid pulses two cycles later with res and flags. A new operation
// may be issued every cycle.

`timescale 1ns/1ps
`default_nettype none

module fadds (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       en,
  input  fadd_ctrl_pkg::op_e         op,
  input  fadd_ctrl_pkg::round_mode_e rmode,
  input  fp_types_pkg::fp32_t        a,
  input  fp_types_pkg::fp32_t        b,
  output logic                       valid,
  output fp_types_pkg::fp32_t        res,
  output fadd_ctrl_pkg::fadd_flags_t flags
);
  import fp_types_pkg::*;
  import fadd_ctrl_pkg::*;

  round_mode_e             rmode_q;
  special_t                spec;
  logic                    en_q;
  align_t                  al;
  logic [SIG_W+GRS_W-1:0]  sig;
  logic signed [9:0]       exp_n;
  logic                    is_zero;

  // rounding mode follows the operation into stage 2
  always_ff @(posedge clk) begin
    rmode_q <= rmode;
  end

  fadd_classify classify_i (
    .clk  (clk),
    .rst  (rst),
    .en   (en),
    .op   (op),
    .a    (a),
    .b    (b),
    .spec (spec),
    .en_q (en_q)
  );

  fadd_align align_i (
    .clk (clk),
    .rst (rst),
    .op  (op),
    .a   (a),
    .b   (b),
    .al  (al)
  );

  fadd_mant_add mant_add_i (
    .al      (al),
    .sig     (sig),
    .exp_n   (exp_n),
    .is_zero (is_zero)
  );

  fadd_round round_i (
    .clk     (clk),
    .rst     (rst),
    .en_q    (en_q),
    .rmode   (rmode_q),
    .sign    (al.sign),
    .sig     (sig),
    .exp_n   (exp_n),
    .is_zero (is_zero),
    .spec    (spec),
    .valid   (valid),
    .res     (res),
    .flags   (flags)
  );

endmodule

`default_nettype wire

/* fp_types_pkg.sv */
// IEEE-754 single-precision number format shared by the adder stages.
// Holds the packed float layout, the field widths and a few fixed encodings.
// Modules import it inside their body and use scoped names in port lists.

`default_nettype none

package fp_types_pkg;

  localparam int EXP_W  = 8;
  localparam int FRAC_W = 23;

  // significand including the hidden bit
  localparam int SIG_W = FRAC_W + 1;

  // guard, round and sticky below the significand
  localparam int GRS_W = 3;

  localparam logic [EXP_W-1:0] EXP_BIAS = 8'd127;
  localparam logic [EXP_W-1:0] EXP_MAX  = 8'hFF;

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [FRAC_W-1:0] frac;
  } fp32_t;

  // canonical quiet NaN
  localparam fp32_t QNAN_VAL = 32'h7FC0_0000;

endpackage

`default_nettype wire

/* tb_fadds_vectors.svh */
// Directed vectors for the adder testbench.
// Included inside the testbench module after the package imports;
// load_vectors fills the table that the testbench applies in order.

`ifndef TB_FADDS_VECTORS_SVH
`define TB_FADDS_VECTORS_SVH

typedef struct packed {
  op_e         op;
  round_mode_e rmode;
  fp32_t       a;
  fp32_t       b;
  fp32_t       res;
  fadd_flags_t flags;
} vec_t;

vec_t  vectors[$];
string vec_names[$];

task automatic add_vector(input string name, input op_e o, input round_mode_e rm,
                          input fp32_t av, input fp32_t bv, input fp32_t rv,
                          input fadd_flags_t fv);
  vec_t v;
  v.op    = o;
  v.rmode = rm;
  v.a     = av;
  v.b     = bv;
  v.res   = rv;
  v.flags = fv;
  vectors.push_back(v);
  vec_names.push_back(name);
endtask

// columns: name, op, rmode, a, b, expected res, expected flags
// flags in hex: invalid 8, overflow 4, underflow 2, inexact 1
task automatic load_vectors();
  add_vector("add_even", OP_ADD, RND_EVEN, 32'h3f800000, 32'h40000000, 32'h40400000, 4'h0);
  add_vector("sub_plus", OP_SUB, RND_PLUS, 32'h40400000, 32'h3f800000, 32'h40000000, 4'h0);
  add_vector("rsub_minus", OP_RSUB, RND_MINUS, 32'h3f800000, 32'h40400000, 32'h40000000, 4'h0);
  add_vector("cancel", OP_SUB, RND_EVEN, 32'h3fc00000, 32'h3fc00000, 32'h00000000, 4'h0);
  add_vector("cancel_mn", OP_SUB, RND_MINUS, 32'h3fc00000, 32'h3fc00000, 32'h80000000, 4'h0);
  // 1.0 plus half an ulp
  add_vector("tie_even", OP_ADD, RND_EVEN, 32'h3f800000, 32'h33800000, 32'h3f800000, 4'h1);
  add_vector("tie_odd", OP_ADD, RND_EVEN, 32'h3f800001, 32'h33800000, 32'h3f800002, 4'h1);
  add_vector("tie_trunc", OP_ADD, RND_TRUNC, 32'h3f800000, 32'h33800000, 32'h3f800000, 4'h1);
  add_vector("tie_plus", OP_ADD, RND_PLUS, 32'h3f800000, 32'h33800000, 32'h3f800001, 4'h1);
  add_vector("tie_mneg", OP_ADD, RND_MINUS, 32'hbf800000, 32'hb3800000, 32'hbf800001, 4'h1);
  add_vector("tie_pneg", OP_ADD, RND_PLUS, 32'hbf800000, 32'hb3800000, 32'hbf800000, 4'h1);
  add_vector("qnan", OP_ADD, RND_EVEN, 32'h7fc00000, 32'h3f800000, 32'h7fc00000, 4'h0);
  add_vector("snan", OP_ADD, RND_EVEN, 32'h7f800001, 32'h3f800000, 32'h7fc00000, 4'h8);
  add_vector("inf_inf", OP_SUB, RND_EVEN, 32'h7f800000, 32'h7f800000, 32'h7fc00000, 4'h8);
  add_vector("inf_one", OP_ADD, RND_EVEN, 32'h3f800000, 32'hff800000, 32'hff800000, 4'h0);
  add_vector("rsub_inf", OP_RSUB, RND_EVEN, 32'h7f800000, 32'h3f800000, 32'hff800000, 4'h0);
  add_vector("zero_x", OP_ADD, RND_EVEN, 32'h00000000, 32'hc0400000, 32'hc0400000, 4'h0);
  add_vector("zero_sub", OP_SUB, RND_EVEN, 32'h00000000, 32'h40000000, 32'hc0000000, 4'h0);
  add_vector("zz_minus", OP_ADD, RND_MINUS, 32'h00000000, 32'h80000000, 32'h80000000, 4'h0);
  add_vector("zz_neg", OP_ADD, RND_EVEN, 32'h80000000, 32'h80000000, 32'h80000000, 4'h0);
  add_vector("denorm", OP_ADD, RND_EVEN, 32'h00000001, 32'h3f800000, 32'h3f800000, 4'h0);
  add_vector("ovf_even", OP_ADD, RND_EVEN, 32'h7f7fffff, 32'h7f7fffff, 32'h7f800000, 4'h5);
  add_vector("ovf_trunc", OP_ADD, RND_TRUNC, 32'h7f7fffff, 32'h7f7fffff, 32'h7f7fffff, 4'h5);
  add_vector("ovf_plus", OP_ADD, RND_PLUS, 32'h7f7fffff, 32'h7f7fffff, 32'h7f800000, 4'h5);
  add_vector("ovf_minus", OP_ADD, RND_MINUS, 32'h7f7fffff, 32'h7f7fffff, 32'h7f7fffff, 4'h5);
  add_vector("ovf_mneg", OP_ADD, RND_MINUS, 32'hff7fffff, 32'hff7fffff, 32'hff800000, 4'h5);
  // rounding carry pushes past the largest finite value
  add_vector("ovf_round", OP_ADD, RND_EVEN, 32'h7f7fffff, 32'h73000000, 32'h7f800000, 4'h5);
  add_vector("unf_pos", OP_SUB, RND_EVEN, 32'h00800001, 32'h00800000, 32'h00000000, 4'h3);
  add_vector("unf_neg", OP_SUB, RND_EVEN, 32'h00800000, 32'h00800001, 32'h80000000, 4'h3);
endtask

`endif

/* tb_fadds.sv */
// Testbench for the pipelined adder.
// Applies the directed table, random logic operations and a back-to-back
// burst with idle slots, then prints the error counts and a verdict.

`timescale 1ns/1ps
`default_nettype none

module tb_fadds;
  import fp_types_pkg::*;
  import fadd_ctrl_pkg::*;

  `include "tb_fadds_vectors.svh"

  localparam int TIMEOUT   = 20;
  localparam int BURST_LEN = 12;

  logic        clk;
  logic        rst;
  logic        en;
  op_e         op;
  round_mode_e rmode;
  fp32_t       a;
  fp32_t       b;
  logic        valid;
  fp32_t       res;
  fadd_flags_t flags;

  integer seed;
  int     res_errs = 0;
  int     flag_errs = 0;
  int     valid_errs = 0;
  int     timeouts = 0;

  // table indices with -1 for an idle slot
  int  burst_slots [BURST_LEN] = '{0, 6, 12, -1, 9, 22, -1, -1, 27, 4, 18, 26};
  op_e logic_ops [4] = '{OP_AND, OP_OR, OP_XOR, OP_ANDN};

  fadds dut_i (
    .clk   (clk),
    .rst   (rst),
    .en    (en),
    .op    (op),
    .rmode (rmode),
    .a     (a),
    .b     (b),
    .valid (valid),
    .res   (res),
    .flags (flags)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_res(input string name, input fp32_t expv, input fp32_t act);
    if (act !== expv) begin
      $display("Fail %s: expected res %h, actual %h", name, expv, act);
      res_errs++;
    end
  endtask

  task automatic check_flags(input string name, input fadd_flags_t expv,
                             input fadd_flags_t act);
    if (act !== expv) begin
      $display("Fail %s: expected flags %b, actual %b", name, expv, act);
      flag_errs++;
    end
  endtask

  task automatic check_valid(input string name, input logic expv, input logic act);
    if (act !== expv) begin
      $display("Fail %s: expected valid %b, actual %b", name, expv, act);
      valid_errs++;
    end
  endtask

  // bitwise ops on the raw 32-bit patterns
  function automatic fp32_t logic_result(input op_e o, input fp32_t x, input fp32_t y);
    case (o)
      OP_AND:  return x & y;
      OP_OR:   return x | y;
      OP_XOR:  return x ^ y;
      default: return x & ~y;
    endcase
  endfunction

  task automatic drive_op(input vec_t v);
    en    = 1'b1;
    op    = v.op;
    rmode = v.rmode;
    a     = v.a;
    b     = v.b;
  endtask

  task automatic wait_valid(input string name, output logic got);
    int cycles;
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      got = valid;
      cycles++;
    end
    if (!got) begin
      $display("Timeout in %s: valid never came within %0d cycles", name, TIMEOUT);
      timeouts++;
    end
  endtask

  task automatic apply_vector(input string name, input vec_t v);
    logic got;
    @(posedge clk);
    #1;
    drive_op(v);
    @(posedge clk);
    #1;
    en = 1'b0;
    wait_valid(name, got);
    if (got) begin
      check_res(name, v.res, res);
      check_flags(name, v.flags, flags);
    end
  endtask

  // results read two edges after each issue slot
  task automatic run_burst();
    int    idx;
    int    last;
    string name;
    last = 0;
    for (int c = 0; c < BURST_LEN + 2; c++) begin
      @(posedge clk);
      #1;
      if (c >= 2) begin
        idx = burst_slots[c-2];
        if (idx < 0) begin
          check_valid("burst idle", 1'b0, valid);
          // outputs hold the previous result
          check_res("burst idle", vectors[last].res, res);
          check_flags("burst idle", vectors[last].flags, flags);
        end else begin
          name = {"burst ", vec_names[idx]};
          check_valid(name, 1'b1, valid);
          check_res(name, vectors[idx].res, res);
          check_flags(name, vectors[idx].flags, flags);
          last = idx;
        end
      end
      if (c < BURST_LEN && burst_slots[c] >= 0) begin
        drive_op(vectors[burst_slots[c]]);
      end else begin
        // operands keep moving while en is low
        en = 1'b0;
        a  = $random(seed);
        b  = $random(seed);
      end
    end
  endtask

  initial begin
    vec_t v;
    rst   = 1'b1;
    en    = 1'b0;
    op    = OP_ADD;
    rmode = RND_EVEN;
    a     = '0;
    b     = '0;
    seed  = 32'h800;
    load_vectors();

    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    check_valid("reset", 1'b0, valid);
    check_res("reset", '0, res);
    check_flags("reset", '0, flags);

    for (int i = 0; i < vectors.size(); i++) begin
      apply_vector(vec_names[i], vectors[i]);
    end

    for (int k = 0; k < 4; k++) begin
      for (int n = 0; n < 6; n++) begin
        v.op    = logic_ops[k];
        v.rmode = RND_EVEN;
        v.a     = $random(seed);
        v.b     = $random(seed);
        v.res   = logic_result(v.op, v.a, v.b);
        v.flags = '0;
        apply_vector($sformatf("logic %s run %0d", v.op.name(), n), v);
      end
    end

    run_burst();

    $display("errors: res %0d, flags %0d, valid %0d, timeouts %0d",
             res_errs, flag_errs, valid_errs, timeouts);
    if (res_errs + flag_errs + valid_errs + timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
